// File: common/rs_pkg.sv
package rs_pkg;

    // reorder-buffer tag, zero means the value is ready
    localparam int TAG_W = 4;

    typedef logic [TAG_W-1:0] rob_tag_t;
    typedef logic [31:0]      word_t;
    typedef logic [3:0]       aluop_t;

    localparam aluop_t ALU_ADD = 4'h0;
    localparam aluop_t ALU_SUB = 4'h1;
    localparam aluop_t ALU_AND = 4'h2;
    localparam aluop_t ALU_OR  = 4'h3;
    localparam aluop_t ALU_XOR = 4'h4;
    localparam aluop_t ALU_SLL = 4'h5;
    localparam aluop_t ALU_SRL = 4'h6;
    localparam aluop_t ALU_SLT = 4'h7;

    // value is only meaningful once tag is zero
    typedef struct packed {
        rob_tag_t tag;
        word_t    value;
    } src_t;

    typedef struct packed {
        rob_tag_t dest;
        aluop_t   op;
        logic     use_imm;
        word_t    imm;
        src_t     src1;
        src_t     src2;
    } dispatch_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t dest;
        aluop_t   op;
        logic     use_imm;
        word_t    imm;
        word_t    val1;
        word_t    val2;
    } issue_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    // take the broadcast value when the operand waits on that tag
    function automatic src_t src_capture(src_t s, cdb_t c);
        src_t r;
        r = s;
        if (c.valid && s.tag != '0 && s.tag == c.tag) begin
            r.tag   = '0;
            r.value = c.value;
        end
        return r;
    endfunction

endpackage

// File: reservation_station/reservation_station.sv
module reservation_station
    import rs_pkg::*;
#(
    parameter int RS_DEPTH = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  dispatch_t alloc_inst,
    input  logic      alloc_valid,
    output logic      rs_full,
    input  cdb_t      cdb,
    output issue_t    issue
);

    localparam int IDX_W = $clog2(RS_DEPTH);

    logic [RS_DEPTH-1:0] busy;
    dispatch_t           ent [RS_DEPTH];
    logic [RS_DEPTH-1:0] ready_vec;

    logic [IDX_W-1:0] alloc_idx;
    logic [IDX_W-1:0] sel_idx;
    logic             sel_found;
    logic             do_alloc;
    dispatch_t        alloc_snooped;

    assign rs_full  = &busy;
    assign do_alloc = alloc_valid && !rs_full && !flush;

    // both operands present
    always_comb begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ready_vec[i] = busy[i] && ent[i].src1.tag == '0 && ent[i].src2.tag == '0;
        end
    end

    // lowest free entry, scanned downward so the lowest index is kept
    always_comb begin
        alloc_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                alloc_idx = IDX_W'(i);
            end
        end
    end

    // lowest ready entry
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (ready_vec[i]) begin
                sel_found = 1'b1;
                sel_idx   = IDX_W'(i);
            end
        end
    end

    // a result broadcast on the write edge must not be missed
    always_comb begin
        alloc_snooped      = alloc_inst;
        alloc_snooped.src1 = src_capture(alloc_inst.src1, cdb);
        alloc_snooped.src2 = src_capture(alloc_inst.src2, cdb);
    end

    // issued entry and new entry never collide, one is busy and one is free
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= '0;
        end else if (flush) begin
            busy <= '0;
        end else begin
            if (sel_found) begin
                busy[sel_idx] <= 1'b0;
            end
            if (do_alloc) begin
                busy[alloc_idx] <= 1'b1;
            end
        end
    end

    // entry payload with cdb snooping
    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (do_alloc && alloc_idx == IDX_W'(i)) begin
                ent[i] <= alloc_snooped;
            end else if (busy[i]) begin
                ent[i].src1 <= src_capture(ent[i].src1, cdb);
                ent[i].src2 <= src_capture(ent[i].src2, cdb);
            end
        end
    end

    // issue register toward the ALU, nothing goes out on a flush edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue <= '0;
        end else begin
            issue.valid   <= sel_found && !flush;
            issue.dest    <= ent[sel_idx].dest;
            issue.op      <= ent[sel_idx].op;
            issue.use_imm <= ent[sel_idx].use_imm;
            issue.imm     <= ent[sel_idx].imm;
            issue.val1    <= ent[sel_idx].src1.value;
            issue.val2    <= ent[sel_idx].src2.value;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# compile with Verilator, run the testbench and scan the log for a failure
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary -j 0 -Wno-fatal \
    --top-module issue_cluster_tb \
    -f verilog.f \
    -o issue_cluster_sim

./obj_dir/issue_cluster_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi

echo "simulation finished without failure"
exit 0

// File: src/alu_unit.sv
module alu_unit
    import rs_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  issue_t issue,
    output cdb_t   cdb
);

    word_t op_a;
    word_t op_b;
    word_t result;
    cdb_t  s1;

    assign op_a = issue.val1;
    // immediate replaces source 2
    assign op_b = issue.use_imm ? issue.imm : issue.val2;

    always_comb begin
        case (issue.op)
            ALU_ADD: result = op_a + op_b;
            ALU_SUB: result = op_a - op_b;
            ALU_AND: result = op_a & op_b;
            ALU_OR:  result = op_a | op_b;
            ALU_XOR: result = op_a ^ op_b;
            ALU_SLL: result = op_a << op_b[4:0];
            ALU_SRL: result = op_a >> op_b[4:0];
            ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
            default: result = '0;
        endcase
    end

    // stage one holds the computed result
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1 <= '0;
        end else begin
            s1.valid <= issue.valid;
            s1.tag   <= issue.dest;
            s1.value <= result;
        end
    end

    // stage two drives the bus, one cycle per result
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cdb <= '0;
        end else begin
            cdb <= s1;
        end
    end

endmodule

// File: src/dispatch_stage.sv
module dispatch_stage
    import rs_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  dispatch_t in_inst,
    input  logic      in_valid,
    output logic      in_ready,
    input  cdb_t      cdb,
    input  logic      rs_full,
    output dispatch_t alloc_inst,
    output logic      alloc_valid
);

    logic      hold_valid;
    dispatch_t hold_inst;
    dispatch_t base_inst;
    dispatch_t next_inst;
    logic      accept;
    logic      drain;

    // station takes the held instruction this cycle
    assign drain  = hold_valid && !rs_full;
    assign accept = in_valid && in_ready;

    assign in_ready = !hold_valid || drain;

    assign alloc_inst  = hold_inst;
    assign alloc_valid = hold_valid;

    // snoop cdb on the held copy, or on the incoming one at the accept edge
    always_comb begin
        base_inst      = accept ? in_inst : hold_inst;
        next_inst      = base_inst;
        next_inst.src1 = src_capture(base_inst.src1, cdb);
        next_inst.src2 = src_capture(base_inst.src2, cdb);
    end

    // a new accept wins over flush and drain
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (accept) begin
            hold_valid <= 1'b1;
        end else if (flush || drain) begin
            hold_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept || hold_valid) begin
            hold_inst <= next_inst;
        end
    end

endmodule

// File: src/issue_cluster.sv
module issue_cluster
    import rs_pkg::*;
#(
    parameter int RS_DEPTH = 8
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  dispatch_t in_inst,
    input  logic      in_valid,
    output logic      in_ready,
    output cdb_t      cdb
);

    dispatch_t alloc_inst;
    logic      alloc_valid;
    logic      rs_full;
    issue_t    issue;

    dispatch_stage dispatch_stage_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_inst     (in_inst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .cdb         (cdb),
        .rs_full     (rs_full),
        .alloc_inst  (alloc_inst),
        .alloc_valid (alloc_valid)
    );

    reservation_station #(
        .RS_DEPTH (RS_DEPTH)
    ) reservation_station_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .alloc_inst  (alloc_inst),
        .alloc_valid (alloc_valid),
        .rs_full     (rs_full),
        .cdb         (cdb),
        .issue       (issue)
    );

    // result bus also feeds back into dispatch and the station
    alu_unit alu_unit_i (
        .clk   (clk),
        .rst   (rst),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

// File: verification/issue_cluster_vectors.svh
// each row holds test, dest tag, op, use_imm, imm, src1 kind, src1 arg, src2 kind,
// src2 arg and flags
// a src arg is a literal (LIT), a producer row index (DEP) or a raw tag (WAIT)
// and is ignored for a random value (RND)
`ifndef ISSUE_CLUSTER_VECTORS_SVH
`define ISSUE_CLUSTER_VECTORS_SVH

task automatic load_vectors();
    // independent ops, one per op code
    add_row(1, 1, ALU_ADD, 0, 0, RND, 0, RND, 0, 0);
    add_row(1, 2, ALU_SUB, 0, 0, RND, 0, RND, 0, 0);
    add_row(1, 3, ALU_AND, 1, 'h0ff0_f00f, RND, 0, LIT, 'h1234_5678, 0);
    add_row(1, 4, ALU_OR, 0, 0, RND, 0, RND, 0, 0);
    add_row(1, 5, ALU_XOR, 1, 'h5555_aaaa, RND, 0, LIT, 7, 0);
    add_row(1, 6, ALU_SLL, 0, 0, RND, 0, LIT, 35, 0);
    add_row(1, 7, ALU_SRL, 1, 36, RND, 0, LIT, 0, 0);
    add_row(1, 8, ALU_SLT, 0, 0, LIT, -5, LIT, 3, 0);
    // dependency chain, both sources on the last two
    add_row(2, 1, ALU_ADD, 1, 100, RND, 0, LIT, 0, 0);
    add_row(2, 2, ALU_SUB, 0, 0, DEP, 8, RND, 0, 0);
    add_row(2, 3, ALU_ADD, 0, 0, DEP, 9, DEP, 9, 0);
    add_row(2, 4, ALU_SLT, 0, 0, DEP, 10, DEP, 8, 0);
    // consumers of row 21 fill the station, producer goes last
    add_row(3, 1, ALU_ADD, 0, 0, DEP, 21, RND, 0, 0);
    add_row(3, 2, ALU_SUB, 0, 0, RND, 0, DEP, 21, 0);
    add_row(3, 3, ALU_AND, 0, 0, DEP, 21, DEP, 21, 0);
    add_row(3, 4, ALU_XOR, 1, 'h00ff, DEP, 21, LIT, 0, 0);
    add_row(3, 5, ALU_SLL, 0, 0, DEP, 21, LIT, 9, 0);
    add_row(3, 6, ALU_SRL, 0, 0, DEP, 21, LIT, 3, 0);
    add_row(3, 7, ALU_SLT, 0, 0, RND, 0, DEP, 21, 0);
    add_row(3, 8, ALU_ADD, 0, 0, RND, 0, RND, 0, 0);
    add_row(3, 9, ALU_OR, 1, 'h1234, RND, 0, LIT, 0, F_STALL);
    add_row(3, 10, ALU_SUB, 0, 0, RND, 0, RND, 0, 0);
    // waiters on tag 15 are flushed, then the fresh group produces tag 15
    add_row(4, 7, ALU_ADD, 0, 0, WAIT, 15, RND, 0, F_KILL);
    add_row(4, 8, ALU_SUB, 0, 0, RND, 0, WAIT, 15, F_KILL);
    add_row(4, 9, ALU_AND, 0, 0, WAIT, 15, WAIT, 15, F_KILL);
    add_row(4, 10, ALU_OR, 0, 0, WAIT, 15, RND, 0, F_KILL);
    add_row(4, 11, ALU_XOR, 0, 0, RND, 0, WAIT, 15, F_KILL);
    add_row(4, 12, ALU_SLL, 0, 0, WAIT, 15, LIT, 2, F_KILL);
    add_row(4, 13, ALU_SRL, 0, 0, WAIT, 15, LIT, 1, F_KILL);
    add_row(4, 14, ALU_SLT, 0, 0, RND, 0, WAIT, 15, F_KILL);
    add_row(4, 15, ALU_ADD, 0, 0, RND, 0, RND, 0, F_FLUSH);
    add_row(4, 2, ALU_AND, 1, 'h00ff_ff00, DEP, 30, LIT, 0, 0);
endtask

`endif

// File: verification/issue_cluster_tb.sv
module issue_cluster_tb
    import rs_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RS_DEPTH = 8;
    localparam int unsigned SEED = 32'h48b0_b881;
    // source kinds and row flags of the vector table
    localparam int LIT = 0, DEP = 1, RND = 2, WAIT = 3;
    localparam int F_FLUSH = 1, F_KILL = 2, F_STALL = 4;

    typedef struct packed {
        int       test;
        rob_tag_t dest;
        aluop_t   op;
        logic     use_imm;
        word_t    imm;
        int       k1;
        int       v1;
        int       k2;
        int       v2;
        logic     do_flush;
        logic     killed;
        logic     stall;
    } row_t;

    logic      clk = 1'b0;
    logic      rst;
    logic      flush;
    dispatch_t in_inst;
    logic      in_valid;
    logic      in_ready;
    cdb_t      cdb;

    row_t  tbl [$];
    word_t rnd_a [64];
    word_t rnd_b [64];
    word_t exp_val [64];
    int    seen_cnt [16];
    word_t seen_val [16];
    logic  got_stall;
    int    cycles = 0;
    int    limit;
    int    cur_test = 0;
    int    errors = 0;
    int    tests = 0;
    int    tests_failed = 0;

    issue_cluster #(
        .RS_DEPTH (RS_DEPTH)
    ) issue_cluster_i (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .in_inst  (in_inst),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .cdb      (cdb)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: test %0d still waiting after %0d cycles", cur_test, cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // bus and handshake are stable at the falling edge
    always @(negedge clk) begin
        if (cdb.valid) begin
            seen_cnt[cdb.tag] = seen_cnt[cdb.tag] + 1;
            seen_val[cdb.tag] = cdb.value;
        end
        if (in_valid && !in_ready) begin
            got_stall = 1'b1;
        end
    end

    task automatic add_row(input int test, input int dest, input aluop_t op, input int use_imm,
                           input int imm, input int k1, input int v1, input int k2,
                           input int v2, input int flags);
        row_t r;
        r = '{test, rob_tag_t'(dest), op, use_imm != 0, word_t'(imm), k1, v1, k2, v2,
              (flags & F_FLUSH) != 0, (flags & F_KILL) != 0, (flags & F_STALL) != 0};
        tbl.push_back(r);
    endtask

    `include "issue_cluster_vectors.svh"

    function automatic word_t alu_ref(aluop_t op, word_t a, word_t b);
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];
            ALU_SRL: return a >> b[4:0];
            ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    function automatic rob_tag_t src_tag(int k, int v);
        if (k == DEP) return tbl[v].dest;
        if (k == WAIT) return rob_tag_t'(v);
        return '0;
    endfunction

    function automatic word_t src_value(int k, int v, word_t rnd);
        if (k == DEP) return exp_val[v];
        if (k == RND) return rnd;
        if (k == LIT) return word_t'(v);
        return '0;
    endfunction

    function automatic logic all_seen(int first, int last);
        for (int i = first; i <= last; i++) begin
            if (!tbl[i].killed && seen_cnt[tbl[i].dest] == 0) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic check_idle();
        if (cdb.valid !== 1'b0) begin
            $display("[ERROR] %0t cdb.valid: expected 0, got %b", $time, cdb.valid);
            errors++;
        end
        if (in_ready !== 1'b1) begin
            $display("[ERROR] %0t in_ready: expected 1, got %b", $time, in_ready);
            errors++;
        end
    endtask

    task automatic clear_monitor();
        for (int t = 0; t < 16; t++) begin
            seen_cnt[t] = 0;
        end
        got_stall = 1'b0;
    endtask

    task automatic pulse_flush();
        in_valid <= 1'b0;
        flush    <= 1'b1;
        @(posedge clk);
        flush    <= 1'b0;
    endtask

    // holds the row on the input until the handshake completes
    task automatic send_row(input int i);
        dispatch_t inst;
        logic      ok;
        inst.dest       = tbl[i].dest;
        inst.op         = tbl[i].op;
        inst.use_imm    = tbl[i].use_imm;
        inst.imm        = tbl[i].imm;
        inst.src1.tag   = src_tag(tbl[i].k1, tbl[i].v1);
        inst.src2.tag   = src_tag(tbl[i].k2, tbl[i].v2);
        // junk in a pending operand must never reach the ALU
        inst.src1.value = (inst.src1.tag != '0) ? 32'hdead_beef
                                                : src_value(tbl[i].k1, tbl[i].v1, rnd_a[i]);
        inst.src2.value = (inst.src2.tag != '0) ? 32'hdead_beef
                                                : src_value(tbl[i].k2, tbl[i].v2, rnd_b[i]);
        in_inst  <= inst;
        in_valid <= 1'b1;
        do begin
            @(negedge clk);
            ok = in_ready;
            @(posedge clk);
        end while (!ok);
    endtask

    task automatic finish_test(input int first, input int last);
        int   want [16];
        int   start;
        logic need_stall;
        start      = errors;
        need_stall = 1'b0;
        while (!all_seen(first, last)) @(posedge clk);
        // quiet window so stray or repeated broadcasts are counted
        repeat (10) @(posedge clk);
        for (int t = 0; t < 16; t++) begin
            want[t] = 0;
        end
        for (int i = first; i <= last; i++) begin
            if (!tbl[i].killed) want[tbl[i].dest] = 1;
            need_stall |= tbl[i].stall;
        end
        for (int t = 0; t < 16; t++) begin
            if (seen_cnt[t] != want[t]) begin
                $display("[ERROR] %0t cdb broadcasts of tag %0d: expected %0d, got %0d",
                         $time, t, want[t], seen_cnt[t]);
                errors++;
            end
        end
        for (int i = first; i <= last; i++) begin
            if (!tbl[i].killed && seen_cnt[tbl[i].dest] > 0 &&
                seen_val[tbl[i].dest] !== exp_val[i]) begin
                $display("[ERROR] %0t cdb.value of tag %0d: expected %h, got %h",
                         $time, tbl[i].dest, exp_val[i], seen_val[tbl[i].dest]);
                errors++;
            end
        end
        if (need_stall && !got_stall) begin
            $display("test %0d: in_ready never went low while the station was full",
                     tbl[first].test);
            errors++;
        end
        tests++;
        if (errors != start) tests_failed++;
        $display("test %0d finished: %0d rows, %0d errors", tbl[first].test,
                 last - first + 1, errors - start);
    endtask

    initial begin
        word_t a;
        word_t b;
        int    start;
        int    first;
        void'($urandom(SEED));
        rst      = 1'b1;
        flush    = 1'b0;
        in_valid = 1'b0;
        in_inst  = '0;
        load_vectors();
        limit = tbl.size() * 20 + 200;
        for (int i = 0; i < tbl.size(); i++) begin
            rnd_a[i] = $urandom();
            rnd_b[i] = $urandom();
        end
        // forward references settle over a few passes
        for (int p = 0; p < 4; p++) begin
            for (int i = 0; i < tbl.size(); i++) begin
                a = src_value(tbl[i].k1, tbl[i].v1, rnd_a[i]);
                b = tbl[i].use_imm ? tbl[i].imm : src_value(tbl[i].k2, tbl[i].v2, rnd_b[i]);
                exp_val[i] = alu_ref(tbl[i].op, a, b);
            end
        end
        clear_monitor();

        start = errors;
        repeat (8) begin
            @(negedge clk);
            check_idle();
        end
        @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_idle();
        tests++;
        if (errors != start) tests_failed++;
        $display("test 0 finished: reset state, %0d errors", errors - start);
        @(posedge clk);

        first = 0;
        for (int i = 0; i < tbl.size(); i++) begin
            cur_test = tbl[i].test;
            if (i == first) clear_monitor();
            if (tbl[i].do_flush) pulse_flush();
            send_row(i);
            if (i == tbl.size() - 1 || tbl[i + 1].test != tbl[i].test) begin
                in_valid <= 1'b0;
                finish_test(first, i);
                first = i + 1;
            end
        end

        $display("summary: %0d tests, %0d failed, %0d errors", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+verification
common/rs_pkg.sv
src/dispatch_stage.sv
reservation_station/reservation_station.sv
src/alu_unit.sv
src/issue_cluster.sv
verification/issue_cluster_tb.sv
